// ==== hdl/user_io_pkg.sv ====
// shared byte and word types, command codes, core type and PS/2 transmitter states
package user_io_pkg;

	// one SPI or PS/2 byte
	typedef logic [7:0] io_byte_t;

	// joystick and status words
	typedef logic [31:0] io_word_t;

	// analog stick pair, X in the upper byte and Y in the lower
	typedef logic [15:0] axis_pair_t;

	// command bytes sent by the io controller
	localparam io_byte_t cmd_but_sw   = 8'h01;
	localparam io_byte_t cmd_mouse    = 8'h04;
	localparam io_byte_t cmd_kbd      = 8'h05;
	localparam io_byte_t cmd_conf_str = 8'h14;
	localparam io_byte_t cmd_status8  = 8'h15;
	localparam io_byte_t cmd_analog   = 8'h1a;
	localparam io_byte_t cmd_status32 = 8'h1e;
	// first of five joystick commands, 0x60 to 0x64
	localparam io_byte_t cmd_joy_base = 8'h60;

	// 8-bit core id, shifted out while the command byte comes in
	localparam io_byte_t core_type = 8'ha4;

	// PS/2 transmitter, named after what is on the data line
	typedef enum logic [2:0] {
		idle,
		start,
		data,
		parity,
		stop
	} ps2_state_t;

endpackage

// ==== hdl/spi_frame_rx.sv ====
// SPI clock side bit and byte counters, MOSI shifter, byte toggle and MISO response mux
`timescale 1ns/1ps

module spi_frame_rx #(
	parameter int strlen = 1,
	parameter logic [8*strlen-1:0] conf_str = "-"
) (
	input  logic                  SPI_CLK,
	input  logic                  SPI_SS_IO,
	input  logic                  SPI_MOSI,
	output logic                  SPI_MISO,
	output user_io_pkg::io_byte_t byte_in,
	output logic                  byte_tgl,
	output logic                  frame_busy
);

	// bit within the current byte
	logic [2:0] bit_cnt;
	// byte number in the frame saturates at the top
	logic [9:0] byte_cnt;
	// first seven bits of the byte being received
	logic [6:0] sbuf;
	user_io_pkg::io_byte_t cmd;
	user_io_pkg::io_byte_t frame_cmd;
	user_io_pkg::io_byte_t next_out;
	user_io_pkg::io_byte_t spi_byte_out;
	// flips once for every finished byte
	logic tgl_q = 1'b0;

	assign byte_tgl = tgl_q;

	// counters and frame level are cleared while the select is high
	always_ff @(posedge SPI_CLK or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			bit_cnt    <= '0;
			byte_cnt   <= '0;
			frame_busy <= 1'b0;
		end else begin
			frame_busy <= 1'b1;
			bit_cnt    <= bit_cnt + 3'd1;
			if (bit_cnt == 3'd7 && ~&byte_cnt)
				byte_cnt <= byte_cnt + 10'd1;
		end
	end

	// on the command byte itself the command is still in the shifter
	always_comb begin
		frame_cmd = (byte_cnt == '0) ? {sbuf, SPI_MOSI} : cmd;
		next_out  = '0;
		// config string goes out first character first
		if (frame_cmd == user_io_pkg::cmd_conf_str && int'(byte_cnt) < strlen)
			next_out = conf_str[(strlen - 1 - int'(byte_cnt)) * 8 +: 8];
	end

	// response byte reloads as the last bit of each byte comes in
	always_ff @(posedge SPI_CLK or posedge SPI_SS_IO) begin
		if (SPI_SS_IO)
			spi_byte_out <= user_io_pkg::core_type;
		else if (bit_cnt == 3'd7)
			spi_byte_out <= next_out;
	end

	// MOSI assembly and handover to clk_sys
	always_ff @(posedge SPI_CLK) begin
		if (bit_cnt != 3'd7) begin
			sbuf <= {sbuf[5:0], SPI_MOSI};
		end else begin
			byte_in <= {sbuf, SPI_MOSI};
			tgl_q   <= ~tgl_q;
			if (byte_cnt == '0)
				cmd <= {sbuf, SPI_MOSI};
		end
	end

	// MSB first on falling edges
	// the clock idles high so the first fall of a frame already shows bit 7
	always_ff @(negedge SPI_CLK or posedge SPI_SS_IO) begin
		if (SPI_SS_IO)
			SPI_MISO <= 1'b0;
		else
			SPI_MISO <= spi_byte_out[~bit_cnt];
	end

endmodule

// ==== hdl/spi_byte_sync.sv ====
// two-flop synchronizers turning the byte toggle and frame level into clk_sys pulses
`timescale 1ns/1ps

module spi_byte_sync (
	input  logic clk_sys,
	input  logic SPI_SS_IO,
	input  logic byte_tgl,
	input  logic frame_busy,
	output logic byte_stb,
	output logic frame_start
);

	// byte toggle path
	logic tgl_meta = 1'b0;
	logic tgl_sync = 1'b0;
	logic tgl_last = 1'b0;
	// frame level path
	logic busy_meta;
	logic busy_sync;
	logic busy_last;

	always_ff @(posedge clk_sys) begin
		tgl_meta <= byte_tgl;
		tgl_sync <= tgl_meta;
		tgl_last <= tgl_sync;
	end

	// frame level drops as soon as the select goes high
	always_ff @(posedge clk_sys or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			busy_meta <= 1'b0;
			busy_sync <= 1'b0;
			busy_last <= 1'b0;
		end else begin
			busy_meta <= frame_busy;
			busy_sync <= busy_meta;
			busy_last <= busy_sync;
		end
	end

	// any toggle edge is one finished byte
	assign byte_stb    = tgl_sync ^ tgl_last;
	assign frame_start = busy_sync & ~busy_last;

endmodule

// ==== hdl/io_cmd_decode.sv ====
// frame byte index, command latch, held joystick/status/button registers and PS/2 push strobes
`timescale 1ns/1ps

module io_cmd_decode (
	input  logic                     clk_sys,
	input  logic                     byte_stb,
	input  logic                     frame_start,
	input  user_io_pkg::io_byte_t    byte_in,
	output user_io_pkg::io_word_t    joystick_0,
	output user_io_pkg::io_word_t    joystick_1,
	output user_io_pkg::io_word_t    joystick_2,
	output user_io_pkg::io_word_t    joystick_3,
	output user_io_pkg::io_word_t    joystick_4,
	output user_io_pkg::axis_pair_t  joystick_analog_0,
	output user_io_pkg::axis_pair_t  joystick_analog_1,
	output logic [1:0]               buttons,
	output logic [1:0]               switches,
	output logic                     scandoubler_disable,
	output logic                     ypbpr,
	output user_io_pkg::io_word_t    status,
	output logic                     kbd_push,
	output logic                     mouse_push,
	output user_io_pkg::io_byte_t    push_byte,
	output logic                     flush
);

	// byte 0 is the command, payload from 1 on
	logic [7:0] byte_idx = '0;
	user_io_pkg::io_byte_t cmd = '0;
	// held registers start at zero and live across frames
	user_io_pkg::io_word_t joy [5] = '{default: '0};
	user_io_pkg::axis_pair_t axis [2] = '{default: '0};
	user_io_pkg::io_word_t status_q = '0;
	logic [5:0] but_sw = '0;
	logic [2:0] stick_idx;
	logic kbd_q = 1'b0;
	logic mouse_q = 1'b0;
	user_io_pkg::io_byte_t push_q;
	user_io_pkg::io_byte_t joy_off;
	logic joy_hit;
	logic word_slot;
	logic [1:0] lane;

	always_comb begin
		joy_off   = cmd - user_io_pkg::cmd_joy_base;
		joy_hit   = joy_off < 8'd5;
		// payload bytes 1 to 4 fill a word LSB first
		word_slot = byte_idx >= 8'd1 && byte_idx <= 8'd4;
		lane      = byte_idx[1:0] - 2'd1;
	end

	always_ff @(posedge clk_sys) begin
		// push strobes last one cycle
		kbd_q   <= 1'b0;
		mouse_q <= 1'b0;
		if (frame_start) begin
			byte_idx <= '0;
		end else if (byte_stb) begin
			if (byte_idx != 8'hff)
				byte_idx <= byte_idx + 8'd1;
			if (byte_idx == '0) begin
				cmd <= byte_in;
			end else begin
				push_q <= byte_in;
				if (joy_hit && word_slot)
					joy[joy_off[2:0]][{lane, 3'b000} +: 8] <= byte_in;
				case (cmd)
					user_io_pkg::cmd_but_sw: but_sw <= byte_in[5:0];
					user_io_pkg::cmd_mouse: mouse_q <= 1'b1;
					user_io_pkg::cmd_kbd: kbd_q <= 1'b1;
					// only the low byte, upper bits are kept
					user_io_pkg::cmd_status8: status_q[7:0] <= byte_in;
					user_io_pkg::cmd_status32: begin
						if (word_slot)
							status_q[{lane, 3'b000} +: 8] <= byte_in;
					end
					// index, then X, then Y; sticks above 1 are dropped
					user_io_pkg::cmd_analog: begin
						if (byte_idx == 8'd1)
							stick_idx <= byte_in[2:0];
						else if (byte_idx == 8'd2 && stick_idx < 3'd2)
							axis[stick_idx[0]][15:8] <= byte_in;
						else if (byte_idx == 8'd3 && stick_idx < 3'd2)
							axis[stick_idx[0]][7:0] <= byte_in;
					end
					default: ;
				endcase
			end
		end
	end

	assign joystick_0          = joy[0];
	assign joystick_1          = joy[1];
	assign joystick_2          = joy[2];
	assign joystick_3          = joy[3];
	assign joystick_4          = joy[4];
	assign joystick_analog_0   = axis[0];
	assign joystick_analog_1   = axis[1];
	assign buttons             = but_sw[1:0];
	assign switches            = but_sw[3:2];
	assign scandoubler_disable = but_sw[4];
	assign ypbpr               = but_sw[5];
	assign status              = status_q;
	assign kbd_push            = kbd_q;
	assign mouse_push          = mouse_q;
	assign push_byte           = push_q;
	// status bit 0 is the core reset from the controller
	assign flush               = status_q[0];

endmodule

// ==== hdl/ps2_tx_channel.sv ====
// one PS/2 transmit channel: 8-entry byte FIFO, clock divider and 11-bit frame serializer
`timescale 1ns/1ps

module ps2_tx_channel #(
	parameter int ps2div = 100
) (
	input  logic                  clk_sys,
	input  logic                  flush,
	input  logic                  push,
	input  user_io_pkg::io_byte_t push_byte,
	output logic                  ps2_clk,
	output logic                  ps2_data
);

	localparam int cnt_w = $clog2(ps2div + 1);

	// no back-pressure, a ninth push runs over unsent data
	user_io_pkg::io_byte_t fifo [8];
	logic [2:0] wptr = '0;
	logic [2:0] rptr = '0;
	// divided clock, ps2div cycles per half period
	logic [cnt_w-1:0] div_cnt = '0;
	logic div_clk = 1'b0;
	logic rise_tick;
	user_io_pkg::ps2_state_t state = user_io_pkg::idle;
	user_io_pkg::io_byte_t tx_byte;
	logic [2:0] bit_idx;
	logic parity_bit;
	logic data_q = 1'b1;

	// high in the cycle the divided clock goes up
	assign rise_tick = (div_cnt == cnt_w'(ps2div - 1)) && !div_clk;

	always_ff @(posedge clk_sys) begin
		if (div_cnt == cnt_w'(ps2div - 1)) begin
			div_cnt <= '0;
			div_clk <= ~div_clk;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// write side
	always_ff @(posedge clk_sys) begin
		if (flush) begin
			wptr <= '0;
		end else if (push) begin
			fifo[wptr] <= push_byte;
			wptr       <= wptr + 3'd1;
		end
	end

	// serializer, data moves on rising edges and the host samples on falling ones
	always_ff @(posedge clk_sys) begin
		if (rise_tick) begin
			case (state)
				user_io_pkg::idle: begin
					if (wptr != rptr) begin
						tx_byte    <= fifo[rptr];
						// odd parity over the data bits
						parity_bit <= ~^fifo[rptr];
						rptr       <= rptr + 3'd1;
						data_q     <= 1'b0;
						state      <= user_io_pkg::start;
					end
				end
				user_io_pkg::start: begin
					data_q  <= tx_byte[0];
					tx_byte <= tx_byte >> 1;
					bit_idx <= '0;
					state   <= user_io_pkg::data;
				end
				user_io_pkg::data: begin
					// bit_idx is the bit now on the line, LSB first
					if (bit_idx == 3'd7) begin
						data_q <= parity_bit;
						state  <= user_io_pkg::parity;
					end else begin
						data_q  <= tx_byte[0];
						tx_byte <= tx_byte >> 1;
						bit_idx <= bit_idx + 3'd1;
					end
				end
				user_io_pkg::parity: begin
					data_q <= 1'b1;
					state  <= user_io_pkg::stop;
				end
				default: state <= user_io_pkg::idle;
			endcase
		end
		if (flush)
			rptr <= '0;
	end

	// clock line parked high while nothing is being sent
	assign ps2_clk  = div_clk | (state == user_io_pkg::idle);
	assign ps2_data = data_q;

endmodule

// ==== hdl/user_io_top.sv ====
// user I/O top: SPI receiver, clk_sys synchronizer, command decoder and two PS/2 channels
`timescale 1ns/1ps

module user_io_top #(
	parameter int strlen = 1,
	parameter logic [8*strlen-1:0] conf_str = "-",
	parameter int ps2div = 100
) (
	input  logic                    clk_sys,
	input  logic                    SPI_CLK,
	input  logic                    SPI_SS_IO,
	input  logic                    SPI_MOSI,
	output logic                    SPI_MISO,
	output user_io_pkg::io_word_t   joystick_0,
	output user_io_pkg::io_word_t   joystick_1,
	output user_io_pkg::io_word_t   joystick_2,
	output user_io_pkg::io_word_t   joystick_3,
	output user_io_pkg::io_word_t   joystick_4,
	output user_io_pkg::axis_pair_t joystick_analog_0,
	output user_io_pkg::axis_pair_t joystick_analog_1,
	output logic [1:0]              buttons,
	output logic [1:0]              switches,
	output logic                    scandoubler_disable,
	output logic                    ypbpr,
	output user_io_pkg::io_word_t   status,
	output logic                    ps2_kbd_clk,
	output logic                    ps2_kbd_data,
	output logic                    ps2_mouse_clk,
	output logic                    ps2_mouse_data
);

	// SPI_CLK domain to clk_sys
	user_io_pkg::io_byte_t byte_in;
	logic byte_tgl;
	logic frame_busy;
	logic byte_stb;
	logic frame_start;
	// decoder to PS/2 channels
	logic kbd_push;
	logic mouse_push;
	user_io_pkg::io_byte_t push_byte;
	logic flush;

	spi_frame_rx #(
		.strlen  (strlen),
		.conf_str(conf_str)
	) spi_frame_rx_inst (
		.SPI_CLK   (SPI_CLK),
		.SPI_SS_IO (SPI_SS_IO),
		.SPI_MOSI  (SPI_MOSI),
		.SPI_MISO  (SPI_MISO),
		.byte_in   (byte_in),
		.byte_tgl  (byte_tgl),
		.frame_busy(frame_busy)
	);

	spi_byte_sync spi_byte_sync_inst (
		.clk_sys    (clk_sys),
		.SPI_SS_IO  (SPI_SS_IO),
		.byte_tgl   (byte_tgl),
		.frame_busy (frame_busy),
		.byte_stb   (byte_stb),
		.frame_start(frame_start)
	);

	io_cmd_decode io_cmd_decode_inst (
		.clk_sys            (clk_sys),
		.byte_stb           (byte_stb),
		.frame_start        (frame_start),
		.byte_in            (byte_in),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.joystick_2         (joystick_2),
		.joystick_3         (joystick_3),
		.joystick_4         (joystick_4),
		.joystick_analog_0  (joystick_analog_0),
		.joystick_analog_1  (joystick_analog_1),
		.buttons            (buttons),
		.switches           (switches),
		.scandoubler_disable(scandoubler_disable),
		.ypbpr              (ypbpr),
		.status             (status),
		.kbd_push           (kbd_push),
		.mouse_push         (mouse_push),
		.push_byte          (push_byte),
		.flush              (flush)
	);

	// keyboard channel
	ps2_tx_channel #(
		.ps2div(ps2div)
	) ps2_kbd_inst (
		.clk_sys  (clk_sys),
		.flush    (flush),
		.push     (kbd_push),
		.push_byte(push_byte),
		.ps2_clk  (ps2_kbd_clk),
		.ps2_data (ps2_kbd_data)
	);

	// mouse channel, same byte bus with its own strobe
	ps2_tx_channel #(
		.ps2div(ps2div)
	) ps2_mouse_inst (
		.clk_sys  (clk_sys),
		.flush    (flush),
		.push     (mouse_push),
		.push_byte(push_byte),
		.ps2_clk  (ps2_mouse_clk),
		.ps2_data (ps2_mouse_data)
	);

endmodule

// ==== sim/user_io_checker.sv ====
// checker: PS/2 frame decoder for both channels and comparison of DUT outputs with expected values
`timescale 1ns/1ps

module user_io_checker (
	input logic clk_sys
);

	int pass_cnt = 0;
	int fail_cnt = 0;
	// decoded bytes per channel, 0 keyboard and 1 mouse
	user_io_pkg::io_byte_t rx_bytes [2][32];
	int rx_count [2] = '{0, 0};
	int falls [2] = '{0, 0};
	int nbits [2] = '{0, 0};
	logic clk_last [2] = '{1'b1, 1'b1};
	logic [10:0] frame [2];
	logic [1:0] line_clk;
	logic [1:0] line_data;

	assign line_clk  = {user_io_tb.user_io_top_inst.ps2_mouse_clk,
		user_io_tb.user_io_top_inst.ps2_kbd_clk};
	assign line_data = {user_io_tb.user_io_top_inst.ps2_mouse_data,
		user_io_tb.user_io_top_inst.ps2_kbd_data};

	task automatic compare(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected === actual) begin
			pass_cnt++;
			$display("Pass %s value %h", name, actual);
		end else begin
			fail_cnt++;
			$display("Fail %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic report_problem(input string what);
		fail_cnt++;
		$display("%s", what);
	endtask

	// held outputs by slot number
	function automatic logic [31:0] read_port(input int sel);
		case (sel)
			0: return user_io_tb.user_io_top_inst.joystick_0;
			1: return user_io_tb.user_io_top_inst.joystick_1;
			2: return user_io_tb.user_io_top_inst.joystick_2;
			3: return user_io_tb.user_io_top_inst.joystick_3;
			4: return user_io_tb.user_io_top_inst.joystick_4;
			5: return {16'd0, user_io_tb.user_io_top_inst.joystick_analog_0};
			6: return {16'd0, user_io_tb.user_io_top_inst.joystick_analog_1};
			7: return user_io_tb.user_io_top_inst.status;
			default: return {26'd0, user_io_tb.user_io_top_inst.ypbpr,
				user_io_tb.user_io_top_inst.scandoubler_disable,
				user_io_tb.user_io_top_inst.switches, user_io_tb.user_io_top_inst.buttons};
		endcase
	endfunction

	task automatic check_reg(input string name, input int sel, input logic [31:0] expected);
		compare(name, expected, read_port(sel));
	endtask

	task automatic check_ps2(input string name, input int ch, input int idx,
			input user_io_pkg::io_byte_t expected);
		if (idx >= rx_count[ch])
			report_problem({name, ": no PS/2 frame arrived"});
		else
			compare(name, {24'd0, expected}, {24'd0, rx_bytes[ch][idx]});
	endtask

	// MISO low, PS/2 lines high, strobes low
	task automatic check_reset();
		compare("reset outputs", 32'h78, {24'd0, user_io_tb.user_io_top_inst.SPI_MISO,
			user_io_tb.user_io_top_inst.ps2_kbd_clk, user_io_tb.user_io_top_inst.ps2_kbd_data,
			user_io_tb.user_io_top_inst.ps2_mouse_clk, user_io_tb.user_io_top_inst.ps2_mouse_data,
			user_io_tb.user_io_top_inst.kbd_push, user_io_tb.user_io_top_inst.mouse_push,
			user_io_tb.user_io_top_inst.byte_stb});
	endtask

	// falling PS/2 clock seen one cycle late, data still stable then
	always @(posedge clk_sys) begin
		for (int ch = 0; ch < 2; ch++) begin
			if (clk_last[ch] && !line_clk[ch]) begin
				falls[ch]++;
				// LSB first, so bits shift in from the top
				frame[ch] = {line_data[ch], frame[ch][10:1]};
				nbits[ch]++;
				if (nbits[ch] == 11) begin
					nbits[ch] = 0;
					// start 0, odd parity over data and parity, stop 1
					if (frame[ch][0] || !frame[ch][10] || !(^frame[ch][9:1]))
						report_problem($sformatf("PS/2 channel %0d sent a badly framed byte %b",
							ch, frame[ch]));
					if (rx_count[ch] < 32) begin
						rx_bytes[ch][rx_count[ch]] = frame[ch][8:1];
						rx_count[ch]++;
					end
				end
			end
			clk_last[ch] = line_clk[ch];
		end
	end

endmodule

// ==== sim/user_io_tb.sv ====
// testbench top: clock, reset, LFSR stimulus, SPI frame driver, reference model and test sequence
`timescale 1ns/1ps

module user_io_tb;

	// SPI half period in clk_sys cycles
	localparam int spi_half = 4;
	localparam int ps2_timeout = 3000;
	// config string reply, then a zero byte
	localparam logic [39:0] conf_reply = {"AB;C", 8'h00};

	logic clk_sys = 1'b0;
	logic SPI_CLK = 1'b1;
	logic SPI_SS_IO = 1'b0;
	logic SPI_MOSI = 1'b0;
	logic SPI_MISO;
	user_io_pkg::io_word_t joystick_0, joystick_1, joystick_2, joystick_3, joystick_4;
	user_io_pkg::axis_pair_t joystick_analog_0, joystick_analog_1;
	logic [1:0] buttons;
	logic [1:0] switches;
	logic scandoubler_disable;
	logic ypbpr;
	user_io_pkg::io_word_t status;
	logic ps2_kbd_clk, ps2_kbd_data, ps2_mouse_clk, ps2_mouse_data;

	logic [31:0] lfsr = 32'd72554;
	// expected held registers: 0-4 joysticks, 5-6 analog pairs, 7 status, 8 buttons/switches
	user_io_pkg::io_word_t model [9] = '{default: '0};
	user_io_pkg::io_byte_t tx_q [$];
	user_io_pkg::io_byte_t rx_q [$];

	always #2 clk_sys = ~clk_sys;

	user_io_top #(
		.strlen  (4),
		.conf_str("AB;C"),
		.ps2div  (3)
	) user_io_top_inst (.*);

	user_io_checker checker_inst (.clk_sys(clk_sys));

	// galois form, taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		return s >> 1;
	endfunction

	// one lfsr step per bit
	task automatic rand_byte(output user_io_pkg::io_byte_t b);
		b = '0;
		for (int i = 0; i < 8; i++) begin
			b    = {b[6:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	task automatic rand_word(output user_io_pkg::io_word_t w);
		user_io_pkg::io_byte_t b;
		for (int i = 0; i < 4; i++) begin
			rand_byte(b);
			w[i*8 +: 8] = b;
		end
	endtask

	// which model slot a frame writes, -1 for none
	function automatic int target_reg(input user_io_pkg::io_byte_t cmd,
			input user_io_pkg::io_byte_t idx);
		if (cmd >= user_io_pkg::cmd_joy_base && cmd < user_io_pkg::cmd_joy_base + 8'd5)
			return int'(cmd - user_io_pkg::cmd_joy_base);
		if (cmd == user_io_pkg::cmd_analog)
			return (idx < 8'd2) ? 5 + int'(idx) : -1;
		if (cmd == user_io_pkg::cmd_status32 || cmd == user_io_pkg::cmd_status8)
			return 7;
		if (cmd == user_io_pkg::cmd_but_sw)
			return 8;
		return -1;
	endfunction

	// new register value, first payload byte in pay[7:0]
	function automatic user_io_pkg::io_word_t ref_value(input user_io_pkg::io_byte_t cmd,
			input user_io_pkg::io_word_t pay, input user_io_pkg::io_word_t old);
		if (cmd == user_io_pkg::cmd_status8)
			return {old[31:8], pay[7:0]};
		if (cmd == user_io_pkg::cmd_but_sw)
			return {26'd0, pay[5:0]};
		// index, X, Y with X on top
		if (cmd == user_io_pkg::cmd_analog)
			return {16'd0, pay[15:8], pay[23:16]};
		if (target_reg(cmd, pay[7:0]) >= 0)
			return pay;
		return old;
	endfunction

	// mode 3 style: fall drives MOSI, rise samples it
	task automatic spi_byte(input user_io_pkg::io_byte_t tx, output user_io_pkg::io_byte_t rx);
		for (int i = 7; i >= 0; i--) begin
			@(posedge clk_sys);
			SPI_CLK  <= 1'b0;
			SPI_MOSI <= tx[i];
			repeat (spi_half) @(posedge clk_sys);
			// MISO has been stable since the fall
			rx[i]   = SPI_MISO;
			SPI_CLK <= 1'b1;
			repeat (spi_half - 1) @(posedge clk_sys);
		end
	endtask

	// whole frame from tx_q, replies land in rx_q
	task automatic send_frame(input string name);
		user_io_pkg::io_byte_t r;
		rx_q.delete();
		@(posedge clk_sys);
		SPI_SS_IO <= 1'b0;
		repeat (2) @(posedge clk_sys);
		foreach (tx_q[i]) begin
			spi_byte(tx_q[i], r);
			rx_q.push_back(r);
		end
		@(posedge clk_sys);
		SPI_SS_IO <= 1'b1;
		repeat (8) @(posedge clk_sys);
		checker_inst.compare({name, " core type"}, 32'ha4, {24'd0, rx_q[0]});
	endtask

	// register frame, then every held register against the model
	task automatic reg_frame(input string name, input user_io_pkg::io_byte_t cmd,
			input user_io_pkg::io_word_t pay, input int npay);
		int sel;
		tx_q.delete();
		tx_q.push_back(cmd);
		for (int i = 0; i < npay; i++)
			tx_q.push_back(pay[i*8 +: 8]);
		send_frame(name);
		sel = target_reg(cmd, pay[7:0]);
		if (sel >= 0)
			model[sel] = ref_value(cmd, pay, model[sel]);
		for (int s = 0; s < 9; s++)
			checker_inst.check_reg($sformatf("%s reg %0d", name, s), s, model[s]);
	endtask

	// n random bytes to one PS/2 channel, 0 keyboard and 1 mouse
	task automatic ps2_test(input string name, input user_io_pkg::io_byte_t cmd,
			input int ch, input int n);
		user_io_pkg::io_byte_t exp [$];
		user_io_pkg::io_byte_t b;
		int base;
		int other_falls;
		int t;
		base        = checker_inst.rx_count[ch];
		other_falls = checker_inst.falls[1 - ch];
		tx_q.delete();
		tx_q.push_back(cmd);
		for (int i = 0; i < n; i++) begin
			rand_byte(b);
			exp.push_back(b);
			tx_q.push_back(b);
		end
		send_frame(name);
		t = 0;
		while (checker_inst.rx_count[ch] < base + n && t < ps2_timeout) begin
			@(posedge clk_sys);
			t++;
		end
		if (checker_inst.rx_count[ch] < base + n)
			checker_inst.report_problem({name, ": timed out waiting for PS/2 frames"});
		for (int i = 0; i < n; i++)
			checker_inst.check_ps2($sformatf("%s byte %0d", name, i), ch, base + i, exp[i]);
		checker_inst.compare({name, " other channel idle"}, other_falls,
			checker_inst.falls[1 - ch]);
	endtask

	initial begin
		user_io_pkg::io_word_t pay;
		@(posedge clk_sys);
		SPI_SS_IO <= 1'b1;
		repeat (8) @(posedge clk_sys);
		checker_inst.check_reset();

		tx_q = '{user_io_pkg::cmd_conf_str, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
		send_frame("conf_str");
		for (int i = 0; i < 5; i++)
			checker_inst.compare($sformatf("conf_str byte %0d", i + 1),
				{24'd0, conf_reply[39 - 8*i -: 8]}, {24'd0, rx_q[i + 1]});

		for (int j = 0; j < 5; j++) begin
			rand_word(pay);
			reg_frame($sformatf("joystick %0d", j), user_io_pkg::cmd_joy_base + 8'(j), pay, 4);
		end
		rand_word(pay);
		reg_frame("status32", user_io_pkg::cmd_status32, pay, 4);
		rand_word(pay);
		reg_frame("status8", user_io_pkg::cmd_status8, pay, 1);
		rand_word(pay);
		reg_frame("but_sw", user_io_pkg::cmd_but_sw, pay, 1);
		for (int k = 0; k < 3; k++) begin
			rand_word(pay);
			pay[7:0] = 8'(k);
			reg_frame($sformatf("analog %0d", k), user_io_pkg::cmd_analog, pay, 3);
		end
		// status bit 0 flushes the PS/2 FIFOs, so clear it first
		reg_frame("status clear", user_io_pkg::cmd_status32, '0, 4);

		ps2_test("kbd", user_io_pkg::cmd_kbd, 0, 3);
		ps2_test("mouse", user_io_pkg::cmd_mouse, 1, 2);

		$display("tests passed %0d failed %0d", checker_inst.pass_cnt, checker_inst.fail_cnt);
		if (checker_inst.fail_cnt == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== verilog.f ====
hdl/user_io_pkg.sv
hdl/spi_frame_rx.sv
hdl/spi_byte_sync.sv
hdl/io_cmd_decode.sv
hdl/ps2_tx_channel.sv
hdl/user_io_top.sv
sim/user_io_checker.sv
sim/user_io_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module user_io_tb -Mdir obj_dir -f verilog.f
./obj_dir/Vuser_io_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "RESULT: FAIL" sim.log; then
	exit 1
fi
grep -q "RESULT: PASS" sim.log
